// ==== pdp8_lite_pkg.sv ====
// Word width is fixed at 12 by the PDP-8 instruction format
// Control enums encode the operation the datapath performs on the next clock edge
package pdp8_lite_pkg;

  localparam int WORD_BITS = 12;

  typedef logic [WORD_BITS-1:0] word_t;

  typedef enum logic [2:0] {
    OP_AND = 3'o0,
    OP_TAD = 3'o1,
    OP_ISZ = 3'o2,
    OP_DCA = 3'o3,
    OP_JMS = 3'o4,
    OP_JMP = 3'o5,
    OP_IOT = 3'o6,
    OP_OPR = 3'o7
  } opcode_t;

  localparam word_t HALT_WORD = 12'o7402;  // Group 2 operate HLT

  // Memory accesses are split into SET, REQ and REL phases
  typedef enum logic [4:0] {
    S_INIT, S_IDLE, S_LOAD_PC,
    S_DEP_SET, S_DEP_REQ, S_DEP_REL,
    S_FETCH_SET, S_FETCH_REQ, S_FETCH_REL, S_DECODE, S_NOP,
    S_EA_CALC, S_IND_SET, S_IND_REQ, S_IND_REL,
    S_RD_SET, S_RD_REQ, S_RD_REL,
    S_AND_EXEC, S_TAD_EXEC, S_ISZ_INC, S_ISZ_WSET,
    S_DCA_SET, S_JMS_SET, S_WR_REQ, S_WR_REL,
    S_DCA_EXEC, S_JMS_EXEC, S_ISZ_SKIP,
    S_JMP, S_HALT
  } ctrl_state_t;

  typedef enum logic [1:0] {AC_NC, AC_CLEAR, AC_AND, AC_TAD} ac_op_t;

  // PC_ISZ adds two when MB is zero, one otherwise
  typedef enum logic [2:0] {PC_NC, PC_SR, PC_P1, PC_JMP, PC_ISZ} pc_op_t;

  typedef enum logic [1:0] {AD_NC, AD_PC, AD_EA} ad_sel_t;

  typedef enum logic [2:0] {WD_NC, WD_SR, WD_AC, WD_MB, WD_PCP1} wd_sel_t;

  typedef enum logic [1:0] {
    EA_NC,
    EA_PAGE,  // Direct address from IR
    EA_IND    // Pointer taken from MB
  } ea_op_t;

  typedef enum logic [1:0] {
    MB_RD,    // Capture read data
    MB_NC,
    MB_INC
  } mb_op_t;

endpackage

// ==== pdp8_controller.sv ====
// Moore FSM for the memory-reference subset; IOT and operate words other than HALT are no-ops
// Each memory state waits on its req/ack phase, so any memory latency is tolerated
module pdp8_controller import pdp8_lite_pkg::*; (
  input  logic    clock,
  input  logic    resetN,
  input  logic    run,
  input  logic    load_pc,
  input  logic    deposit,
  input  word_t   ir,
  input  logic    mem_ack,
  output ac_op_t  ac_op,
  output pc_op_t  pc_op,
  output ad_sel_t ad_sel,
  output wd_sel_t wd_sel,
  output ea_op_t  ea_op,
  output mb_op_t  mb_op,
  output logic    ir_load,
  output logic    mem_req,
  output logic    mem_write,
  output logic    cpu_idle,
  output logic    halted
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  ctrl_state_t exec_entry;  // First state of the remembered instruction
  opcode_t     op_q;
  opcode_t     ir_op;

  assign ir_op = opcode_t'(ir[11:9]);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= S_INIT;
      op_q  <= OP_AND;
    end else begin
      state <= next_state;
      if (state == S_DECODE) begin
        op_q <= ir_op;  // Held for the address and execute states
      end
    end
  end

  always_comb begin
    case (op_q)
      OP_AND, OP_TAD, OP_ISZ: exec_entry = S_RD_SET;
      OP_DCA:                 exec_entry = S_DCA_SET;
      OP_JMS:                 exec_entry = S_JMS_SET;
      default:                exec_entry = S_JMP;
    endcase
  end

  always_comb begin
    next_state = state;  // Hold by default
    case (state)
      S_INIT:      next_state = S_IDLE;
      S_IDLE: begin
        if (run) begin
          next_state = S_FETCH_SET;
        end else if (load_pc) begin
          next_state = S_LOAD_PC;
        end else if (deposit) begin
          next_state = S_DEP_SET;
        end
      end
      S_DEP_SET:   next_state = S_DEP_REQ;
      S_DEP_REQ:   if (mem_ack) next_state = S_DEP_REL;
      S_DEP_REL:   if (!mem_ack) next_state = S_IDLE;
      S_FETCH_SET: next_state = S_FETCH_REQ;
      S_FETCH_REQ: if (mem_ack) next_state = S_FETCH_REL;
      S_FETCH_REL: if (!mem_ack) next_state = S_DECODE;
      S_DECODE: begin
        if (ir == HALT_WORD) begin
          next_state = S_HALT;
        end else if (ir_op == OP_IOT || ir_op == OP_OPR) begin
          next_state = S_NOP;
        end else begin
          next_state = S_EA_CALC;
        end
      end
      S_EA_CALC:   next_state = ir[8] ? S_IND_SET : exec_entry;
      S_IND_SET:   next_state = S_IND_REQ;
      S_IND_REQ:   if (mem_ack) next_state = S_IND_REL;
      S_IND_REL:   if (!mem_ack) next_state = exec_entry;
      S_RD_SET:    next_state = S_RD_REQ;
      S_RD_REQ:    if (mem_ack) next_state = S_RD_REL;
      S_RD_REL: begin
        if (!mem_ack) begin
          next_state = (op_q == OP_AND) ? S_AND_EXEC :
                       (op_q == OP_TAD) ? S_TAD_EXEC : S_ISZ_INC;
        end
      end
      S_ISZ_INC:   next_state = S_ISZ_WSET;
      S_ISZ_WSET,
      S_DCA_SET,
      S_JMS_SET:   next_state = S_WR_REQ;
      S_WR_REQ:    if (mem_ack) next_state = S_WR_REL;
      S_WR_REL: begin
        if (!mem_ack) begin
          next_state = (op_q == OP_ISZ) ? S_ISZ_SKIP :
                       (op_q == OP_DCA) ? S_DCA_EXEC : S_JMS_EXEC;
        end
      end
      S_HALT:      if (!run) next_state = S_IDLE;
      default:     next_state = S_IDLE;  // Execute states and load PC finish here
    endcase
  end

  always_comb begin
    ac_op     = AC_NC;
    pc_op     = PC_NC;
    ad_sel    = AD_NC;
    wd_sel    = WD_NC;
    ea_op     = EA_NC;
    mb_op     = MB_NC;
    ir_load   = 1'b0;
    mem_req   = 1'b0;
    mem_write = 1'b0;
    cpu_idle  = 1'b0;
    halted    = 1'b0;
    case (state)
      S_INIT:      ac_op = AC_CLEAR;
      S_IDLE:      cpu_idle = 1'b1;
      S_LOAD_PC:   pc_op = PC_SR;
      S_DEP_SET: begin
        ad_sel = AD_PC;  // Address latches the old PC
        wd_sel = WD_SR;
        pc_op  = PC_P1;
      end
      S_DEP_REQ, S_WR_REQ: begin
        mem_req   = 1'b1;
        mem_write = 1'b1;
      end
      S_DEP_REL, S_WR_REL: mem_write = 1'b1;
      S_FETCH_SET: ad_sel = AD_PC;
      S_FETCH_REQ, S_IND_REQ, S_RD_REQ: begin
        mem_req = 1'b1;
        mb_op   = MB_RD;  // Last capture lands while ack is high
      end
      S_FETCH_REL: ir_load = 1'b1;
      S_EA_CALC:   ea_op = EA_PAGE;
      S_IND_SET, S_RD_SET: ad_sel = AD_EA;
      S_IND_REL:   ea_op = EA_IND;
      S_AND_EXEC: begin
        ac_op = AC_AND;
        pc_op = PC_P1;
      end
      S_TAD_EXEC: begin
        ac_op = AC_TAD;
        pc_op = PC_P1;
      end
      S_ISZ_INC:   mb_op = MB_INC;
      S_ISZ_WSET:  wd_sel = WD_MB;
      S_DCA_SET: begin
        ad_sel = AD_EA;
        wd_sel = WD_AC;
      end
      S_JMS_SET: begin
        ad_sel = AD_EA;
        wd_sel = WD_PCP1;  // Return address from the old PC
        pc_op  = PC_JMP;
      end
      S_DCA_EXEC: begin
        ac_op = AC_CLEAR;
        pc_op = PC_P1;
      end
      S_JMS_EXEC, S_NOP: pc_op = PC_P1;
      S_ISZ_SKIP:  pc_op = PC_ISZ;
      S_JMP:       pc_op = PC_JMP;
      S_HALT:      halted = 1'b1;
      default:     ;
    endcase
  end

endmodule

// ==== pdp8_datapath.sv ====
// Machine registers of the core; AC, link and PC are cleared by reset
// IR, EA, MB and the memory address and write-data registers are undefined until first loaded
module pdp8_datapath import pdp8_lite_pkg::*; (
  input  logic    clock,
  input  logic    resetN,
  input  word_t   switch_reg,
  input  ac_op_t  ac_op,
  input  pc_op_t  pc_op,
  input  ad_sel_t ad_sel,
  input  wd_sel_t wd_sel,
  input  ea_op_t  ea_op,
  input  mb_op_t  mb_op,
  input  logic    ir_load,
  input  word_t   mem_rdata,
  output word_t   ir,
  output word_t   mem_addr,
  output word_t   mem_wdata,
  output word_t   ac,
  output word_t   pc,
  output logic    link
);

  word_t              ea;
  word_t              mb;
  word_t              pc_plus1;
  word_t              ea_page;
  logic [WORD_BITS:0] tad_sum;  // Carry out in the top bit

  assign pc_plus1 = pc + word_t'(1);
  assign tad_sum  = {1'b0, ac} + {1'b0, mb};

  // IR bit 7 selects the current page, otherwise page zero
  assign ea_page = {(ir[7] ? pc[11:7] : 5'b00000), ir[6:0]};

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
      pc   <= '0;
    end else begin
      case (ac_op)
        AC_CLEAR: ac <= '0;
        AC_AND:   ac <= ac & mb;
        AC_TAD: begin
          ac   <= tad_sum[WORD_BITS-1:0];
          link <= link ^ tad_sum[WORD_BITS];  // Carry complements the link
        end
        default:  ;
      endcase
      case (pc_op)
        PC_SR:   pc <= switch_reg;
        PC_P1:   pc <= pc_plus1;
        PC_JMP:  pc <= ea;
        PC_ISZ:  pc <= (mb == '0) ? pc + word_t'(2) : pc_plus1;  // Skip on zero result
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ir_load) begin
      ir <= mb;
    end
    case (ea_op)
      EA_PAGE: ea <= ea_page;
      EA_IND:  ea <= mb;
      default: ;
    endcase
    case (mb_op)
      MB_RD:   mb <= mem_rdata;
      MB_INC:  mb <= mb + word_t'(1);
      default: ;
    endcase
    case (ad_sel)
      AD_PC:   mem_addr <= pc;
      AD_EA:   mem_addr <= ea;
      default: ;
    endcase
    case (wd_sel)
      WD_SR:   mem_wdata <= switch_reg;
      WD_AC:   mem_wdata <= ac;
      WD_MB:   mem_wdata <= mb;
      WD_PCP1: mem_wdata <= pc_plus1;
      default: ;
    endcase
  end

endmodule

// ==== pdp8_memory.sv ====
// Word memory with a four-phase req/ack responder, one access per request
// MEM_WORDS must be at least 2; contents are undefined until written
module pdp8_memory import pdp8_lite_pkg::*; #(
  parameter int MEM_WORDS = 4096
) (
  input  logic  clock,
  input  logic  resetN,
  input  logic  mem_req,
  input  logic  mem_write,
  input  word_t mem_addr,
  input  word_t mem_wdata,
  output word_t mem_rdata,
  output logic  mem_ack
);

  localparam int ADDR_BITS = $clog2(MEM_WORDS);

  typedef enum logic {RSP_IDLE, RSP_ACK} rsp_state_t;

  word_t                mem [MEM_WORDS];
  rsp_state_t           rsp_state;
  logic [ADDR_BITS-1:0] index;
  logic                 access;

  assign index   = ADDR_BITS'(mem_addr % MEM_WORDS);  // Address wraps at the array size
  assign access  = mem_req && (rsp_state == RSP_IDLE);
  assign mem_ack = (rsp_state == RSP_ACK);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      rsp_state <= RSP_IDLE;
    end else if (access) begin
      rsp_state <= RSP_ACK;
    end else if (!mem_req) begin
      rsp_state <= RSP_IDLE;  // Release once the request falls
    end
  end

  always_ff @(posedge clock) begin
    if (access && mem_write) begin
      mem[index] <= mem_wdata;
    end
    if (access && !mem_write) begin
      mem_rdata <= mem[index];  // Held until the next read
    end
  end

endmodule

// ==== pdp8_lite.sv ====
// Top level of the cut-down PDP-8 core with front panel controls
// Only the memory depth is configurable; the word width is fixed
module pdp8_lite import pdp8_lite_pkg::*; #(
  parameter int MEM_WORDS = 4096
) (
  input  logic  clock,
  input  logic  resetN,
  input  word_t switch_reg,
  input  logic  load_pc,
  input  logic  deposit,
  input  logic  run,
  output word_t ac,
  output word_t pc,
  output logic  link,
  output logic  cpu_idle,
  output logic  halted
);

  ac_op_t  ac_op;
  pc_op_t  pc_op;
  ad_sel_t ad_sel;
  wd_sel_t wd_sel;
  ea_op_t  ea_op;
  mb_op_t  mb_op;
  logic    ir_load;
  word_t   ir;
  logic    mem_req;
  logic    mem_write;
  logic    mem_ack;
  word_t   mem_addr;
  word_t   mem_wdata;
  word_t   mem_rdata;

  pdp8_controller u_controller (
    .clock     (clock),
    .resetN    (resetN),
    .run       (run),
    .load_pc   (load_pc),
    .deposit   (deposit),
    .ir        (ir),
    .mem_ack   (mem_ack),
    .ac_op     (ac_op),
    .pc_op     (pc_op),
    .ad_sel    (ad_sel),
    .wd_sel    (wd_sel),
    .ea_op     (ea_op),
    .mb_op     (mb_op),
    .ir_load   (ir_load),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .cpu_idle  (cpu_idle),
    .halted    (halted)
  );

  pdp8_datapath u_datapath (
    .clock      (clock),
    .resetN     (resetN),
    .switch_reg (switch_reg),
    .ac_op      (ac_op),
    .pc_op      (pc_op),
    .ad_sel     (ad_sel),
    .wd_sel     (wd_sel),
    .ea_op      (ea_op),
    .mb_op      (mb_op),
    .ir_load    (ir_load),
    .mem_rdata  (mem_rdata),
    .ir         (ir),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .ac         (ac),
    .pc         (pc),
    .link       (link)
  );

  pdp8_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) u_memory (
    .clock     (clock),
    .resetN    (resetN),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_ack   (mem_ack)
  );

endmodule

// ==== pdp8_lite_checker.sv ====
// Compares AC, link and PC with the expected values at each rising edge of halted
// Samples on the falling clock edge, where all DUT outputs are settled
module pdp8_lite_checker import pdp8_lite_pkg::*; (
  input  logic         clock,
  input  logic         resetN,
  input  logic         halted,
  input  word_t        ac,
  input  word_t        pc,
  input  logic         link,
  input  logic [127:0] test_name,
  input  word_t        exp_ac,
  input  word_t        exp_pc,
  input  logic         exp_link,
  output int           error_count,
  output int           check_count
);

  logic halted_q;

  // Prints a Fail line and returns 1 on a mismatch
  function automatic int compare_field(input string field, input word_t expected,
                                       input word_t actual);
    if (actual !== expected) begin
      $display("Fail %0s %0s: expected %04o, actual %04o", test_name, field, expected, actual);
      return 1;
    end
    return 0;
  endfunction

  initial begin
    error_count = 0;
    check_count = 0;
  end

  always @(negedge clock) begin : watch
    int bad;
    bad = 0;
    if (!resetN) begin
      halted_q <= 1'b0;
    end else begin
      halted_q <= halted;
      if (halted && !halted_q) begin  // First cycle of HALT
        bad += compare_field("ac", exp_ac, ac);
        bad += compare_field("link", {11'b0, exp_link}, {11'b0, link});
        bad += compare_field("pc", exp_pc, pc);
        check_count <= check_count + 1;
        error_count <= error_count + bad;
      end
    end
  end

endmodule

// ==== pdp8_lite_tb.sv ====
// Loads each program through the front panel, runs it to HALT and lets the checker compare
// AC and link carry over between programs; each program clears AC with a DCA first
module pdp8_lite_tb import pdp8_lite_pkg::*; ();

  localparam int MAX_ROWS = 8;

  logic         clock;
  logic         resetN;
  word_t        switch_reg;
  logic         load_pc;
  logic         deposit;
  logic         run;
  word_t        ac;
  word_t        pc;
  logic         link;
  logic         cpu_idle;
  logic         halted;
  logic [127:0] cur_name;
  word_t        exp_ac;
  word_t        exp_pc;
  logic         exp_link;
  int           error_count;
  int           check_count;
  int           cycle_limit;
  int           num_rows;
  logic [127:0] t_name  [MAX_ROWS];
  word_t        t_load  [MAX_ROWS];
  word_t        t_start [MAX_ROWS];
  int           t_count [MAX_ROWS];
  word_t        t_ac    [MAX_ROWS];
  logic         t_link  [MAX_ROWS];
  word_t        t_pc    [MAX_ROWS];
  word_t        prog    [MAX_ROWS*8];  // Eight word slots per row

  pdp8_lite #(.MEM_WORDS(4096)) uut (
    .clock      (clock),
    .resetN     (resetN),
    .switch_reg (switch_reg),
    .load_pc    (load_pc),
    .deposit    (deposit),
    .run        (run),
    .ac         (ac),
    .pc         (pc),
    .link       (link),
    .cpu_idle   (cpu_idle),
    .halted     (halted)
  );

  pdp8_lite_checker u_checker (
    .clock       (clock),
    .resetN      (resetN),
    .halted      (halted),
    .ac          (ac),
    .pc          (pc),
    .link        (link),
    .test_name   (cur_name),
    .exp_ac      (exp_ac),
    .exp_pc      (exp_pc),
    .exp_link    (exp_link),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Words are packed first word in the top 12 bits
  task automatic add_row(input logic [127:0] name, input word_t load_addr, input word_t start_addr,
                         input int count, input logic [95:0] words,
                         input word_t a, input logic l, input word_t p);
    int k;
    t_name[num_rows]  = name;
    t_load[num_rows]  = load_addr;
    t_start[num_rows] = start_addr;
    t_count[num_rows] = count;
    t_ac[num_rows]    = a;
    t_link[num_rows]  = l;
    t_pc[num_rows]    = p;
    for (k = 0; k < 8; k++) begin
      prog[num_rows*8+k] = words[95-12*k -: 12];
    end
    num_rows++;
  endtask

  // One front panel command, held for a single cycle, then wait for idle
  task automatic panel_op(input logic is_deposit, input word_t value);
    @(negedge clock);
    switch_reg = value;
    load_pc    = !is_deposit;
    deposit    = is_deposit;
    @(negedge clock);
    load_pc = 1'b0;
    deposit = 1'b0;
    while (!cpu_idle) @(negedge clock);
  endtask

  task automatic run_to_halt();
    @(negedge clock);
    run = 1'b1;
    while (!halted) @(negedge clock);
    run = 1'b0;
    while (!cpu_idle) @(negedge clock);
  endtask

  initial begin : stimulus
    int i;
    int j;
    int total_words;
    int missing;
    resetN     = 1'b0;
    switch_reg = '0;
    load_pc    = 1'b0;
    deposit    = 1'b0;
    run        = 1'b0;
    cur_name   = "reset";
    exp_ac     = '0;
    exp_pc     = '0;
    exp_link   = 1'b0;
    num_rows   = 0;
    total_words = 0;
    missing    = 0;
    add_row("deposit_run", 12'o0020, 12'o0020, 5,
            {12'o3024, 12'o1023, 12'o7402, 12'o0123, 48'o0}, 12'o0123, 1'b0, 12'o0022);
    add_row("tad_carry", 12'o0030, 12'o0030, 8,
            {12'o3077, 12'o1035, 12'o1036, 12'o0037, 12'o7402, 12'o7000, 12'o1234, 12'o0070},
            12'o0030, 1'b1, 12'o0034);  // 7000+1234 wraps to 0234 and flips link
    add_row("dca_tad", 12'o0040, 12'o0040, 7,
            {12'o3077, 12'o1045, 12'o3046, 12'o1046, 12'o7402, 12'o0555, 12'o0000, 12'o0},
            12'o0555, 1'b1, 12'o0044);
    add_row("isz_skip", 12'o0050, 12'o0050, 8,
            {12'o3077, 12'o2056, 12'o1057, 12'o2057, 12'o1057, 12'o7402, 12'o7777, 12'o0001},
            12'o0002, 1'b1, 12'o0055);  // TAD at 0052 is skipped
    add_row("jms_jmp_ind", 12'o0060, 12'o0060, 8,
            {12'o3077, 12'o4467, 12'o7402, 12'o0000, 12'o1066, 12'o5463, 12'o0321, 12'o0063},
            12'o0321, 1'b1, 12'o0062);
    // Page-zero 0054 and 0055 still hold isz_skip code, which would give 1002
    add_row("cur_page", 12'o0250, 12'o0250, 6,
            {12'o3077, 12'o1254, 12'o0255, 12'o7402, 12'o0246, 12'o0707, 24'o0},
            12'o0206, 1'b1, 12'o0253);
    for (i = 0; i < num_rows; i++) begin
      total_words += t_count[i];
    end
    cycle_limit = 60 * total_words;
    repeat (5) @(negedge clock);
    resetN = 1'b1;
    while (!cpu_idle) @(negedge clock);
    for (i = 0; i < num_rows; i++) begin
      cur_name = t_name[i];
      exp_ac   = t_ac[i];
      exp_pc   = t_pc[i];
      exp_link = t_link[i];
      panel_op(1'b0, t_load[i]);
      for (j = 0; j < t_count[i]; j++) begin
        panel_op(1'b1, prog[i*8+j]);
      end
      panel_op(1'b0, t_start[i]);
      run_to_halt();
    end
    repeat (2) @(negedge clock);
    if (check_count != num_rows) begin
      missing = num_rows - check_count;
      $display("Only %0d of %0d programs were checked at a halt", check_count, num_rows);
    end
    $display("Summary: %0d halts checked, %0d value errors, %0d missing checks",
             check_count, error_count, missing);
    if (error_count == 0 && missing == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout after %0d cycles, test %0s never reached halt or idle", cycles, cur_name);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== pdp8_lite.f ====
pdp8_lite_pkg.sv
pdp8_controller.sv
pdp8_datapath.sv
pdp8_memory.sv
pdp8_lite.sv
pdp8_lite_checker.sv
pdp8_lite_tb.sv

// ==== Bender.yml ====
package:
  name: pdp8_lite

sources:
  - pdp8_lite_pkg.sv
  - pdp8_controller.sv
  - pdp8_datapath.sv
  - pdp8_memory.sv
  - pdp8_lite.sv
  - target: test
    files:
      - pdp8_lite_checker.sv
      - pdp8_lite_tb.sv
